/* include/rvExec_defines.svh */
////////////////////
// widths, opcode and funct7 values for the RV32I execute front end
// include wherever XLEN or an opcode value is needed
////////////////////
`ifndef RVEXEC_DEFINES_SVH
`define RVEXEC_DEFINES_SVH

// widths
`define XLEN   32
`define REG_AW 5

// base opcodes
`define OPC_COMPUTE  7'b0110011
`define OPC_ICOMPUTE 7'b0010011
`define OPC_BRANCH   7'b1100011
`define OPC_LOAD     7'b0000011
`define OPC_STORE    7'b0100011
`define OPC_JAL      7'b1101111
`define OPC_JALR     7'b1100111
`define OPC_LUI      7'b0110111
`define OPC_AUIPC    7'b0010111

// funct7 values
`define F7_BASE 7'h00
`define F7_ALT  7'h20 // sub, sra, srai

`endif

/* source/rvExecPkg.sv */
////////////////////
// shared types for the execute front end
// stage payloads, control encodings and the branch rule
////////////////////
`include "rvExec_defines.svh"

package rvExecPkg;

    typedef enum logic [2:0] {
        IMM_R, // no immediate
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SI // shift amount, zero extended
    } immSelT;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_PC4,
        WB_IMM
    } wbSelT;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } memSizeT;

    typedef enum logic [1:0] {
        HALT_NONE,
        HALT_ILLEGAL,
        HALT_MEM_ALIGN,
        HALT_TARGET_ALIGN
    } haltCauseT;

    // decode -> execute payload
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   rs1Val;
        logic [`XLEN-1:0]   rs2Val;
        logic [`XLEN-1:0]   imm;
        logic [6:0]         opcode;
        logic [2:0]         funct3;
        logic               srcASel; // 1 = pc
        logic               srcBSel; // 1 = immediate
        logic               aluAlt;  // sub / sra
        wbSelT              wbSel;
        logic               wbEn;
        logic [`REG_AW-1:0] rd;
        logic               isBranch;
        logic               isJump;
        logic               memRead;
        logic               memWrite;
        memSizeT            memSize;
        logic               illegal;
    } decodedT;

    // execute -> output payload
    typedef struct packed {
        logic [`XLEN-1:0]   result;
        logic [`XLEN-1:0]   nextPc;
        logic               wbEn;
        logic [`REG_AW-1:0] rd;
        logic               memWrite;
        memSizeT            memSize;
        haltCauseT          haltCause;
    } execT;

    // conditional branch rule, false for the two unused funct3 codes
    function automatic logic branchOk(input logic [2:0] funct3,
                                      input logic [`XLEN-1:0] a,
                                      input logic [`XLEN-1:0] b);
        logic ok;
        case (funct3)
            3'b000:  ok = (a == b);                   // beq
            3'b001:  ok = (a != b);                   // bne
            3'b100:  ok = ($signed(a) < $signed(b));  // blt
            3'b101:  ok = ($signed(a) >= $signed(b)); // bge
            3'b110:  ok = (a < b);                    // bltu
            3'b111:  ok = (a >= b);                   // bgeu
            default: ok = 1'b0;
        endcase
        return ok;
    endfunction

endpackage

/* source/immGen.sv */
////////////////////
// immediate generator, combinational
// immSel picks the instruction format to slice
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module immGen (
    input  logic [`XLEN-1:0]  instr,
    input  rvExecPkg::immSelT immSel,
    output logic [`XLEN-1:0]  imm
);
    import rvExecPkg::*;

    always_comb begin
        case (immSel)
            IMM_I:
                imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B: // offset in halfwords
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            IMM_U:
                imm = {instr[31:12], 12'b0};
            IMM_J:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            IMM_SI:
                imm = {27'b0, instr[24:20]}; // shamt only
            default:
                imm = '0; // register format
        endcase
    end

endmodule

/* source/controlDecoder.sv */
////////////////////
// instruction decoder feeding the decode register
// produces control fields, the immediate and the illegal flag
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module controlDecoder (
    input  logic [`XLEN-1:0]  instr,
    input  logic [`XLEN-1:0]  pc,
    input  logic [`XLEN-1:0]  rs1Val,
    input  logic [`XLEN-1:0]  rs2Val,
    output rvExecPkg::decodedT decoded
);
    import rvExecPkg::*;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    immSelT           immSel;
    logic [`XLEN-1:0] imm;
    wbSelT            wbSel;
    memSizeT          memSize;
    logic             srcASel;
    logic             srcBSel;
    logic             wbEn;
    logic             isBranch;
    logic             isJump;
    logic             memRead;
    logic             memWrite;
    logic             illegal;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        immSel   = IMM_R;
        wbSel    = WB_ALU;
        srcASel  = 1'b0;
        srcBSel  = 1'b1; // most formats use the immediate
        wbEn     = 1'b0;
        isBranch = 1'b0;
        isJump   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            `OPC_COMPUTE: begin
                srcBSel = 1'b0;
                wbEn    = 1'b1;
                illegal = !(funct7 == `F7_BASE ||
                            (funct7 == `F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            `OPC_ICOMPUTE: begin
                immSel = (funct3[1:0] == 2'b01) ? IMM_SI : IMM_I; // slli, srli, srai
                wbEn   = 1'b1;
                if (funct3 == 3'b001)
                    illegal = (funct7 != `F7_BASE);
                else if (funct3 == 3'b101)
                    illegal = (funct7 != `F7_BASE) && (funct7 != `F7_ALT);
            end
            `OPC_LOAD: begin
                immSel  = IMM_I;
                wbEn    = 1'b1;
                memRead = 1'b1;
                illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            `OPC_STORE: begin
                immSel   = IMM_S;
                memWrite = 1'b1;
                illegal  = funct3[2] || (funct3[1:0] == 2'b11);
            end
            `OPC_BRANCH: begin
                immSel   = IMM_B;
                srcASel  = 1'b1;
                isBranch = 1'b1;
                illegal  = (funct3[2:1] == 2'b01);
            end
            `OPC_JAL: begin
                immSel  = IMM_J;
                srcASel = 1'b1;
                wbSel   = WB_PC4;
                wbEn    = 1'b1;
                isJump  = 1'b1;
            end
            `OPC_JALR: begin
                immSel = IMM_I;
                wbSel  = WB_PC4;
                wbEn   = 1'b1;
                isJump = 1'b1;
            end
            `OPC_LUI: begin
                immSel = IMM_U;
                wbSel  = WB_IMM;
                wbEn   = 1'b1;
            end
            `OPC_AUIPC: begin
                immSel  = IMM_U;
                srcASel = 1'b1;
                wbEn    = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    // size from funct3, word for the reserved code
    always_comb begin
        case (funct3[1:0])
            2'b00:   memSize = SIZE_BYTE;
            2'b01:   memSize = SIZE_HALF;
            default: memSize = SIZE_WORD;
        endcase
    end

    immGen immGenInst (
        .instr  (instr),
        .immSel (immSel),
        .imm    (imm)
    );

    always_comb begin
        decoded.pc       = pc;
        decoded.rs1Val   = rs1Val;
        decoded.rs2Val   = rs2Val;
        decoded.imm      = imm;
        decoded.opcode   = opcode;
        decoded.funct3   = funct3;
        decoded.srcASel  = srcASel;
        decoded.srcBSel  = srcBSel;
        decoded.aluAlt   = (funct7 == `F7_ALT);
        decoded.wbSel    = wbSel;
        decoded.wbEn     = wbEn && !illegal;
        decoded.rd       = instr[11:7];
        decoded.isBranch = isBranch;
        decoded.isJump   = isJump;
        decoded.memRead  = memRead;
        decoded.memWrite = memWrite && !illegal;
        decoded.memSize  = memSize;
        decoded.illegal  = illegal;
    end

endmodule

/* source/intAlu.sv */
////////////////////
// RV32I integer ALU, combinational
// useAdd forces an add for addresses and targets
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module intAlu (
    input  logic [`XLEN-1:0] opA,
    input  logic [`XLEN-1:0] opB,
    input  logic [2:0]       funct3,
    input  logic             aluAlt,
    input  logic             isOpImm,
    input  logic             useAdd,
    output logic [`XLEN-1:0] out
);
    logic [4:0] shamt;

    assign shamt = opB[4:0];

    always_comb begin
        out = opA + opB; // add, also for loads, stores, jumps
        if (!useAdd) begin
            case (funct3)
                3'b000: begin
                    if (aluAlt && !isOpImm)
                        out = opA - opB; // sub, never for addi
                end
                3'b001: out = opA << shamt;
                3'b010: out = {{(`XLEN-1){1'b0}}, ($signed(opA) < $signed(opB))};
                3'b011: out = {{(`XLEN-1){1'b0}}, (opA < opB)};
                3'b100: out = opA ^ opB;
                3'b101: begin
                    if (aluAlt)
                        out = $signed(opA) >>> shamt; // sra
                    else
                        out = opA >> shamt;
                end
                3'b110: out = opA | opB;
                default: out = opA & opB;
            endcase
        end
    end

endmodule

/* source/branchCompare.sv */
////////////////////
// taken decision for branches and jumps
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module branchCompare (
    input  logic [`XLEN-1:0] rs1Val,
    input  logic [`XLEN-1:0] rs2Val,
    input  logic [2:0]       funct3,
    input  logic             isBranch,
    input  logic             isJump,
    output logic             taken
);
    import rvExecPkg::*;

    logic condOk;

    assign condOk = branchOk(funct3, rs1Val, rs2Val);

    always_comb begin
        if (isJump)
            taken = 1'b1; // jal, jalr
        else if (isBranch)
            taken = condOk;
        else
            taken = 1'b0;
    end

endmodule

/* source/pipeStage.sv */
////////////////////
// one-entry valid/ready register
// payloadT sets what travels through it
////////////////////
`timescale 1ns/10ps

module pipeStage #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    upValid,
    output logic    upReady,
    input  payloadT upData,
    output logic    downValid,
    input  logic    downReady,
    output payloadT downData
);
    logic    full;
    payloadT dataQ;

    assign upReady   = !full || downReady; // empty or draining this cycle
    assign downValid = full;
    assign downData  = dataQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            full <= 1'b0;
        else if (upReady)
            full <= upValid;
    end

    always_ff @(posedge clk) begin
        if (upValid && upReady)
            dataQ <= upData;
    end

    // a stalled offer from upstream stays put until taken
    upOfferHeld: assert property (@(posedge clk) disable iff (!arstN)
        upValid && !upReady |=> upValid && $stable(upData));

endmodule

/* source/executeStage.sv */
////////////////////
// execute logic between the decode and output registers
// ALU, branch decision, writeback mux, next PC, halt cause
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module executeStage (
    input  rvExecPkg::decodedT decoded,
    output rvExecPkg::execT    executed
);
    import rvExecPkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] aluOut;
    logic [`XLEN-1:0] pcPlus4;
    logic             isOpImm;
    logic             useAdd;
    logic             taken;
    logic             memMisaligned;
    logic             targetMisaligned;
    haltCauseT        haltCause;

    assign opA     = decoded.srcASel ? decoded.pc : decoded.rs1Val;
    assign opB     = decoded.srcBSel ? decoded.imm : decoded.rs2Val;
    assign isOpImm = (decoded.opcode == `OPC_ICOMPUTE);
    assign useAdd  = !isOpImm && (decoded.opcode != `OPC_COMPUTE);
    assign pcPlus4 = decoded.pc + `XLEN'd4;

    intAlu alu (
        .opA     (opA),
        .opB     (opB),
        .funct3  (decoded.funct3),
        .aluAlt  (decoded.aluAlt),
        .isOpImm (isOpImm),
        .useAdd  (useAdd),
        .out     (aluOut)
    );

    branchCompare brCmp (
        .rs1Val   (decoded.rs1Val),
        .rs2Val   (decoded.rs2Val),
        .funct3   (decoded.funct3),
        .isBranch (decoded.isBranch),
        .isJump   (decoded.isJump),
        .taken    (taken)
    );

    // aluOut is the address for loads and stores
    assign memMisaligned = (decoded.memRead || decoded.memWrite) &&
                           ((decoded.memSize == SIZE_HALF && aluOut[0]) ||
                            (decoded.memSize == SIZE_WORD && aluOut[1:0] != 2'b00));
    assign targetMisaligned = taken && (aluOut[1:0] != 2'b00);

    always_comb begin
        if (decoded.illegal)
            haltCause = HALT_ILLEGAL;
        else if (memMisaligned)
            haltCause = HALT_MEM_ALIGN;
        else if (targetMisaligned)
            haltCause = HALT_TARGET_ALIGN;
        else
            haltCause = HALT_NONE;
    end

    always_comb begin
        case (decoded.wbSel)
            WB_PC4:  executed.result = pcPlus4;
            WB_IMM:  executed.result = decoded.imm; // lui
            default: executed.result = aluOut;
        endcase
        executed.nextPc    = taken ? aluOut : pcPlus4;
        executed.wbEn      = decoded.wbEn && (haltCause == HALT_NONE);
        executed.rd        = decoded.rd;
        executed.memWrite  = decoded.memWrite && (haltCause == HALT_NONE);
        executed.memSize   = decoded.memSize;
        executed.haltCause = haltCause;
    end

endmodule

/* source/rvExecUnit.sv */
////////////////////
// RV32I execute front end, top level
// one instruction in per cycle, result out two cycles later
// valid/ready handshake on both sides
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module rvExecUnit (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 inValid,
    output logic                 inReady,
    input  logic [`XLEN-1:0]     instr,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1Val,
    input  logic [`XLEN-1:0]     rs2Val,
    output logic                 outValid,
    input  logic                 outReady,
    output logic [`XLEN-1:0]     result,
    output logic [`XLEN-1:0]     nextPc,
    output logic                 wbEn,
    output logic [`REG_AW-1:0]   rd,
    output logic                 memWrite,
    output rvExecPkg::memSizeT   memSize,
    output rvExecPkg::haltCauseT haltCause
);
    import rvExecPkg::*;

    decodedT decodedComb;
    decodedT decodedQ;
    execT    execComb;
    execT    execQ;
    logic    decValid;
    logic    exeReady; // back-pressure from exeReg into decReg

    controlDecoder decoder (
        .instr   (instr),
        .pc      (pc),
        .rs1Val  (rs1Val),
        .rs2Val  (rs2Val),
        .decoded (decodedComb)
    );

    pipeStage #(.payloadT(decodedT)) decReg (
        .clk       (clk),
        .arstN     (arstN),
        .upValid   (inValid),
        .upReady   (inReady),
        .upData    (decodedComb),
        .downValid (decValid),
        .downReady (exeReady),
        .downData  (decodedQ)
    );

    executeStage execute (
        .decoded  (decodedQ),
        .executed (execComb)
    );

    pipeStage #(.payloadT(execT)) exeReg (
        .clk       (clk),
        .arstN     (arstN),
        .upValid   (decValid),
        .upReady   (exeReady),
        .upData    (execComb),
        .downValid (outValid),
        .downReady (outReady),
        .downData  (execQ)
    );

    assign result    = execQ.result;
    assign nextPc    = execQ.nextPc;
    assign wbEn      = execQ.wbEn;
    assign rd        = execQ.rd;
    assign memWrite  = execQ.memWrite;
    assign memSize   = execQ.memSize;
    assign haltCause = execQ.haltCause;

endmodule

/* test/rvExecTb.sv */
////////////////////
// testbench for the RV32I execute front end
// random instructions from an LCG, reference model, in-order scoreboard
////////////////////
`timescale 1ns/10ps
`include "rvExec_defines.svh"

module rvExecTb;
    localparam int NUM_PHASE1  = 250; // outReady held high
    localparam int NUM_TXN     = 400; // rest runs with back-pressure
    localparam int CYCLE_LIMIT = 4 * NUM_TXN + 100;

    typedef struct packed {
        logic [31:0] result;
        logic [31:0] nextPc;
        logic        wbEn;
        logic [4:0]  rd;
        logic        memWrite;
        logic [1:0]  memSize;
        logic [1:0]  haltCause; // none, illegal, memory, target
        logic        checkResult;
        logic        checkSize;
        logic [3:0]  cls;
    } expT;

    logic clk = 1'b0;
    logic arstN, inValid, inReady, outValid, outReady, wbEn, memWrite;
    logic [31:0] instr, pc, rs1Val, rs2Val, result, nextPc;
    logic [4:0] rd;
    rvExecPkg::memSizeT memSize;
    rvExecPkg::haltCauseT haltCause;
    logic [3:0] cls; // class of the instruction on the inputs
    logic [31:0] seed = 32'ha0b9d7f4;
    expT expQ[$];
    int accepted = 0;
    int stretch = 0;
    int cycleCount = 0;

    always #10 clk = ~clk;

    rvExecUnit dut (
        .clk(clk), .arstN(arstN), .inValid(inValid), .inReady(inReady),
        .instr(instr), .pc(pc), .rs1Val(rs1Val), .rs2Val(rs2Val),
        .outValid(outValid), .outReady(outReady), .result(result), .nextPc(nextPc),
        .wbEn(wbEn), .rd(rd), .memWrite(memWrite), .memSize(memSize),
        .haltCause(haltCause)
    );

    function automatic logic [31:0] lcgNext();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 15); // fold high bits into the weak low ones
    endfunction

    function automatic string className(input logic [3:0] c);
        case (c)
            4'd0: return "compute";
            4'd1: return "icompute";
            4'd2: return "branch";
            4'd3: return "load";
            4'd4: return "store";
            4'd5: return "jal";
            4'd6: return "jalr";
            4'd7: return "lui";
            4'd8: return "auipc";
            default: return "corrupt";
        endcase
    endfunction

    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic condTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic expT expectExec(input logic [31:0] w, input logic [31:0] p,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic [3:0] c);
        logic [6:0]  op, f7;
        logic [2:0]  f3;
        logic [31:0] immI, immS, immB, immU, immJ, pc4, res, target;
        logic        illegal, taken, isMem, isStore, wb, misMem, misTgt;
        logic [1:0]  size, halt;
        expT         e;
        op = w[6:0];
        f3 = w[14:12];
        f7 = w[31:25];
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        immU = {w[31:12], 12'h0};
        immJ = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        pc4 = p + 32'd4;
        res = 32'd0;
        target = pc4;
        {illegal, taken, isMem, isStore, wb} = 5'b0;
        size = (f3[1:0] == 2'b00) ? 2'd0 : (f3[1:0] == 2'b01) ? 2'd1 : 2'd2;
        case (op)
            `OPC_COMPUTE: begin
                illegal = !(f7 == `F7_BASE || (f7 == `F7_ALT && (f3 == 3'd0 || f3 == 3'd5)));
                res = aluRef(f3, f7 == `F7_ALT, a, b);
                wb = 1'b1;
            end
            `OPC_ICOMPUTE: begin
                if (f3 == 3'd1)
                    illegal = (f7 != `F7_BASE);
                else if (f3 == 3'd5)
                    illegal = (f7 != `F7_BASE) && (f7 != `F7_ALT);
                res = aluRef(f3, f3 == 3'd5 && f7 == `F7_ALT, a,
                             (f3[1:0] == 2'b01) ? {27'b0, w[24:20]} : immI);
                wb = 1'b1;
            end
            `OPC_LOAD: begin
                illegal = (f3 == 3'd3) || (f3 >= 3'd6);
                res = a + immI;
                {isMem, wb} = 2'b11;
            end
            `OPC_STORE: begin
                illegal = (f3 > 3'd2);
                res = a + immS;
                {isMem, isStore} = 2'b11;
            end
            `OPC_BRANCH: begin
                illegal = (f3 == 3'd2) || (f3 == 3'd3);
                res = p + immB; // target also on the result port
                target = res;
                taken = !illegal && condTaken(f3, a, b);
            end
            `OPC_JAL: begin
                {res, target, taken, wb} = {pc4, p + immJ, 2'b11};
            end
            `OPC_JALR: begin
                {res, target, taken, wb} = {pc4, a + immI, 2'b11};
            end
            `OPC_LUI:   {res, wb} = {immU, 1'b1};
            `OPC_AUIPC: {res, wb} = {p + immU, 1'b1};
            default:    illegal = 1'b1;
        endcase
        misMem = isMem && ((size == 2'd1 && res[0]) || (size == 2'd2 && res[1:0] != 2'b00));
        misTgt = taken && (target[1:0] != 2'b00);
        halt = illegal ? 2'd1 : misMem ? 2'd2 : misTgt ? 2'd3 : 2'd0;
        e.result = res;
        e.nextPc = taken ? target : pc4;
        e.wbEn = wb && (halt == 2'd0);
        e.rd = w[11:7];
        e.memWrite = isStore && (halt == 2'd0);
        e.memSize = size;
        e.haltCause = halt;
        e.checkResult = !illegal; // result of an illegal word is undefined
        e.checkSize = isMem && !illegal;
        e.cls = c;
        return e;
    endfunction

    // puts a fresh instruction of a random class on the inputs
    task automatic driveNext();
        logic [31:0] r, a, b, sel;
        logic [6:0]  f7, opc;
        logic [2:0]  f3;
        logic [3:0]  c;
        r = lcgNext();
        a = lcgNext();
        b = lcgNext();
        sel = lcgNext() % 32'd10;
        c = sel[3:0];
        if (r[29:28] == 2'b00)
            b = a; // equal operands so branches go both ways
        f3 = r[14:12];
        f7 = r[31:25];
        opc = `OPC_COMPUTE;
        case (c)
            4'd0: f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? `F7_ALT : `F7_BASE;
            4'd1: begin
                opc = `OPC_ICOMPUTE;
                if (f3 == 3'd1 || f3 == 3'd5)
                    f7 = (f3 == 3'd5 && r[30]) ? `F7_ALT : `F7_BASE;
            end
            4'd2: {opc, f3} = {`OPC_BRANCH, (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3};
            4'd3: {opc, f3} = {`OPC_LOAD, (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3};
            4'd4: {opc, f3} = {`OPC_STORE, (f3[1:0] == 2'b11) ? 3'd2 : {1'b0, f3[1:0]}};
            4'd5: opc = `OPC_JAL;
            4'd6: {opc, f3} = {`OPC_JALR, 3'd0};
            4'd7: opc = `OPC_LUI;
            4'd8: opc = `OPC_AUIPC;
            default: begin
                case (r[6:5])
                    2'b00: opc = r[6:0]; // any opcode, mostly unknown
                    2'b01: {opc, f3} = {`OPC_LOAD, r[13] ? 3'd3 : {2'b11, r[12]}};
                    2'b10: {opc, f3} = {`OPC_STORE, 3'b100 | f3};
                    default: f7 = f7 | 7'h01; // neither base nor alt
                endcase
            end
        endcase
        instr <= {f7, r[24:15], f3, r[11:7], opc};
        pc <= lcgNext() & ~32'h3;
        rs1Val <= a;
        rs2Val <= b;
        cls <= c;
    endtask

    task automatic abortRun();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkField(input string field, input logic [3:0] c,
                              input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("** Error %s %s: expected %h, actual %h", className(c), field, exp, act);
            abortRun();
        end
    endtask

    always @(posedge clk) begin : compareOutputs
        expT e;
        if (arstN && outValid && outReady) begin
            assert (expQ.size() != 0) else begin
                $display("output handshake with no instruction pending");
                abortRun();
            end
            e = expQ.pop_front();
            checkField("haltCause", e.cls, e.haltCause, haltCause);
            checkField("nextPc", e.cls, e.nextPc, nextPc);
            checkField("wbEn", e.cls, e.wbEn, wbEn);
            checkField("memWrite", e.cls, e.memWrite, memWrite);
            checkField("rd", e.cls, e.rd, rd);
            if (e.checkResult)
                checkField("result", e.cls, e.result, result);
            if (e.checkSize)
                checkField("memSize", e.cls, e.memSize, memSize);
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            abortRun();
        end
    end

    initial begin
        {arstN, inValid, outReady} = 3'b001;
        {instr, pc, rs1Val, rs2Val} = '0;
        cls = 4'd0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        assert (!outValid && inReady) else begin
            $display("outValid or inReady wrong after reset");
            abortRun();
        end
        while (accepted < NUM_TXN) begin
            @(posedge clk);
            if (inValid && inReady) begin
                expQ.push_back(expectExec(instr, pc, rs1Val, rs2Val, cls));
                accepted = accepted + 1;
            end
            if (!inValid || inReady) begin // payload may change
                if (accepted >= NUM_TXN) begin
                    inValid <= 1'b0;
                end else if (accepted < NUM_PHASE1 || lcgNext() % 32'd4 != 0) begin
                    driveNext();
                    inValid <= 1'b1;
                end else begin
                    inValid <= 1'b0;
                end
            end
            if (accepted < NUM_PHASE1) begin
                outReady <= 1'b1;
            end else if (stretch == 0) begin
                outReady <= !outReady; // long stall or drain stretch
                stretch = 3 + lcgNext() % 32'd10;
            end else begin
                stretch = stretch - 1;
            end
        end
        outReady <= 1'b1;
        while (expQ.size() != 0)
            @(posedge clk);
        repeat (5) @(posedge clk); // stray outputs show up here
        if (!outValid) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("outputs left over at the end of the run");
            abortRun();
        end
    end

endmodule

/* verilog.f */
+incdir+include
source/rvExecPkg.sv
source/immGen.sv
source/controlDecoder.sv
source/intAlu.sv
source/branchCompare.sv
source/pipeStage.sv
source/executeStage.sv
source/rvExecUnit.sv
test/rvExecTb.sv
